// File: rtl/rob_pkg.sv
package rob_pkg;

    // register value and program counter
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;

    // architectural register index, x0 is never renamed
    typedef logic [4:0] reg_idx_t;

    // control register bus
    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_CTRL    = 2'd0;
    localparam cfg_addr_t CFG_MARGIN  = 2'd1;
    localparam cfg_addr_t CFG_COMMITS = 2'd2;
    localparam cfg_addr_t CFG_FLUSHES = 2'd3;

    // full asserts this many entries before the queue is really full
    localparam data_t MARGIN_RESET = 32'd4;

endpackage

// File: rtl/rob_wb_if.sv
`timescale 1ns/1ns

// execution result into the reorder buffer, one beat per cycle with valid high
interface rob_wb_if #(
    parameter int rob_depth = 16
);
    import rob_pkg::*;

    localparam int idx_w = $clog2(rob_depth);
    localparam int tag_w = idx_w + 1;

    logic             valid;
    logic [tag_w-1:0] rob_id;
    data_t            result;
    addr_t            target_pc;
    logic             jump;

    modport source (output valid, rob_id, result, target_pc, jump);
    modport sink (input valid, rob_id, result, target_pc, jump);

endinterface

// retired entry, valid for one cycle per commit
interface rob_commit_if #(
    parameter int rob_depth = 16
);
    import rob_pkg::*;

    localparam int idx_w = $clog2(rob_depth);
    localparam int tag_w = idx_w + 1;

    logic             valid;
    reg_idx_t         rd;
    logic [tag_w-1:0] tag;
    data_t            value;
    logic             jump;
    addr_t            target_pc;

    modport retire (output valid, rd, tag, value, jump, target_pc);
    modport observe (input valid, rd, tag, value, jump, target_pc);

endinterface

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer #(
    parameter int rob_depth = 16,
    localparam int idx_w = $clog2(rob_depth),
    localparam int tag_w = idx_w + 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  rob_pkg::data_t    full_margin,
    input  logic              dispatch_valid,
    input  rob_pkg::reg_idx_t dispatch_rd,
    output logic [tag_w-1:0]  dispatch_rob_id,
    output logic              full,
    input  logic [tag_w-1:0]  q1,
    input  logic [tag_w-1:0]  q2,
    output logic              q1_ready,
    output logic              q2_ready,
    output rob_pkg::data_t    q1_data,
    output rob_pkg::data_t    q2_data,
    rob_wb_if.sink            alu_wb,
    input  logic              mem_wb_valid,
    input  logic [tag_w-1:0]  mem_wb_rob_id,
    input  rob_pkg::data_t    mem_wb_result,
    input  logic [tag_w-1:0]  store_ready_rob_id,
    input  logic [tag_w-1:0]  io_rob_id,
    output logic [tag_w-1:0]  head_io_rob_id,
    rob_commit_if.retire      commit
);
    import rob_pkg::*;

    // tag = index + 1, tag 0 is no entry
    function automatic logic [idx_w-1:0] tag_to_idx(input logic [tag_w-1:0] tag);
        return idx_w'(tag - 1'b1);
    endfunction

    logic [idx_w-1:0]     head;
    logic [idx_w-1:0]     tail;
    logic [idx_w:0]       count;
    logic [rob_depth-1:0] busy;
    logic [rob_depth-1:0] ready;
    logic [rob_depth-1:0] io;
    logic [rob_depth-1:0] ent_jump;
    reg_idx_t             ent_rd [rob_depth];
    data_t                ent_value [rob_depth];
    addr_t                ent_target [rob_depth];

    logic [idx_w-1:0] alu_idx;
    logic [idx_w-1:0] mem_idx;
    logic [idx_w-1:0] st_idx;
    logic [idx_w-1:0] io_idx;
    logic             live;
    logic             do_commit;
    logic             do_alloc;
    logic             alu_hit;
    logic             mem_hit;
    logic             st_hit;
    logic             io_hit;

    assign alu_idx = tag_to_idx(alu_wb.rob_id);
    assign mem_idx = tag_to_idx(mem_wb_rob_id);
    assign st_idx  = tag_to_idx(store_ready_rob_id);
    assign io_idx  = tag_to_idx(io_rob_id);

    // a registered jump commit flushes at this edge, hold freezes the rest
    assign live      = !hold && !commit.jump;
    assign do_commit = live && busy[head] && ready[head];
    assign do_alloc  = live && dispatch_valid;
    assign alu_hit   = live && alu_wb.valid && busy[alu_idx];
    assign mem_hit   = live && mem_wb_valid && busy[mem_idx];
    assign st_hit    = live && (store_ready_rob_id != '0) && busy[st_idx];
    assign io_hit    = live && (io_rob_id != '0) && busy[io_idx];

    assign dispatch_rob_id = tag_w'(tail) + 1'b1;
    assign full            = (32'(count) + full_margin) >= 32'(rob_depth);
    assign head_io_rob_id  = (busy[head] && io[head]) ? tag_w'(head) + 1'b1 : '0;

    // operand queries
    assign q1_ready = (q1 != '0) && ready[tag_to_idx(q1)];
    assign q2_ready = (q2 != '0) && ready[tag_to_idx(q2)];
    assign q1_data  = (q1 != '0) ? ent_value[tag_to_idx(q1)] : '0;
    assign q2_data  = (q2 != '0) ? ent_value[tag_to_idx(q2)] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n || commit.jump) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            busy         <= '0;
            ready        <= '0;
            io           <= '0;
            commit.valid <= 1'b0;
            commit.jump  <= 1'b0;
        end else begin
            if (alu_hit) ready[alu_idx] <= 1'b1;
            if (mem_hit) ready[mem_idx] <= 1'b1;
            if (st_hit) ready[st_idx] <= 1'b1;
            if (io_hit) io[io_idx] <= 1'b1;

            commit.valid <= do_commit;
            commit.jump  <= do_commit && ent_jump[head];
            if (do_commit) begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                io[head]    <= 1'b0;
                head <= (head == idx_w'(rob_depth - 1)) ? '0 : head + 1'b1;
            end

            if (do_alloc) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                io[tail]    <= 1'b0;
                tail <= (tail == idx_w'(rob_depth - 1)) ? '0 : tail + 1'b1;
            end

            case ({do_alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload and commit fields
    always_ff @(posedge clk) begin
        if (alu_hit) begin
            ent_value[alu_idx]  <= alu_wb.result;
            ent_target[alu_idx] <= alu_wb.target_pc;
            ent_jump[alu_idx]   <= alu_wb.jump;
        end
        if (mem_hit) ent_value[mem_idx] <= mem_wb_result;

        if (do_commit) begin
            commit.rd        <= ent_rd[head];
            commit.tag       <= tag_w'(head) + 1'b1;
            commit.value     <= ent_value[head];
            commit.target_pc <= ent_target[head];
        end

        // stores retire with value 0 unless a result arrives
        if (do_alloc) begin
            ent_rd[tail]     <= dispatch_rd;
            ent_value[tail]  <= '0;
            ent_target[tail] <= '0;
            ent_jump[tail]   <= 1'b0;
        end
    end

    // full depends on the margin programmed in the control block
    a_dispatch_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid && !commit.jump |-> !full && !hold);

    a_alu_tag_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb.valid |-> alu_wb.rob_id != '0);

    a_mem_tag_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wb_valid |-> mem_wb_rob_id != '0);

endmodule

// File: rtl/rename_regfile.sv
`timescale 1ns/1ns

module rename_regfile #(
    parameter int rob_depth = 16,
    localparam int idx_w = $clog2(rob_depth),
    localparam int tag_w = idx_w + 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dispatch_valid,
    input  rob_pkg::reg_idx_t dispatch_rd,
    input  logic [tag_w-1:0]  dispatch_rob_id,
    input  rob_pkg::reg_idx_t rs1_idx,
    input  rob_pkg::reg_idx_t rs2_idx,
    output logic [tag_w-1:0]  rs1_tag,
    output logic [tag_w-1:0]  rs2_tag,
    output rob_pkg::data_t    rs1_value,
    output rob_pkg::data_t    rs2_value,
    rob_commit_if.observe     commit
);
    import rob_pkg::*;

    data_t            values [32];
    logic [tag_w-1:0] tags [32];

    logic commit_wr;
    logic rename_wr;

    // x0 is never written, so it reads value 0 and tag 0
    assign commit_wr = commit.valid && (commit.rd != '0);
    assign rename_wr = dispatch_valid && (dispatch_rd != '0) && !commit.jump;

    assign rs1_tag   = tags[rs1_idx];
    assign rs2_tag   = tags[rs2_idx];
    assign rs1_value = values[rs1_idx];
    assign rs2_value = values[rs2_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                values[i] <= '0;
                tags[i]   <= '0;
            end
        end else begin
            if (commit_wr) begin
                values[commit.rd] <= commit.value;
                // a younger rename of the same register keeps its tag
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end

            if (commit.jump) begin
                for (int i = 0; i < 32; i++) begin
                    tags[i] <= '0;
                end
            end else if (rename_wr) begin
                // same-cycle dispatch beats the commit clear
                tags[dispatch_rd] <= dispatch_rob_id;
            end
        end
    end

    // the buffer never hands out tag 0
    a_rename_tag_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        rename_wr |-> dispatch_rob_id != '0);

endmodule

// File: rtl/rob_ctrl_regs.sv
`timescale 1ns/1ns

module rob_ctrl_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_we,
    input  rob_pkg::cfg_addr_t cfg_addr,
    input  rob_pkg::data_t     cfg_wdata,
    output rob_pkg::data_t     cfg_rdata,
    output logic               hold,
    output rob_pkg::data_t     full_margin,
    rob_commit_if.observe      commit
);
    import rob_pkg::*;

    data_t commit_cnt;
    data_t flush_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold        <= 1'b0;
            full_margin <= MARGIN_RESET;
        end else if (cfg_we) begin
            if (cfg_addr == CFG_CTRL) hold <= cfg_wdata[0];
            if (cfg_addr == CFG_MARGIN) full_margin <= cfg_wdata;
        end
    end

    // counters are read only, any write clears them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_cnt <= '0;
            flush_cnt  <= '0;
        end else begin
            if (cfg_we && cfg_addr == CFG_COMMITS) begin
                commit_cnt <= '0;
            end else if (commit.valid) begin
                commit_cnt <= commit_cnt + 1'b1;
            end

            if (cfg_we && cfg_addr == CFG_FLUSHES) begin
                flush_cnt <= '0;
            end else if (commit.jump) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_CTRL:    cfg_rdata = {31'd0, hold};
            CFG_MARGIN:  cfg_rdata = full_margin;
            CFG_COMMITS: cfg_rdata = commit_cnt;
            default:     cfg_rdata = flush_cnt;
        endcase
    end

    // flush count relies on jump only rising with a commit beat
    a_jump_is_commit: assert property (@(posedge clk) disable iff (!rst_n)
        commit.jump |-> commit.valid);

endmodule

// File: rtl/rob_core_top.sv
`timescale 1ns/1ns

module rob_core_top #(
    parameter int rob_depth = 16,
    localparam int idx_w = $clog2(rob_depth),
    localparam int tag_w = idx_w + 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dispatch_valid,
    input  rob_pkg::reg_idx_t  dispatch_rd,
    output logic [tag_w-1:0]   dispatch_rob_id,
    output logic               full,
    input  rob_pkg::reg_idx_t  rs1_idx,
    input  rob_pkg::reg_idx_t  rs2_idx,
    output logic [tag_w-1:0]   rs1_tag,
    output logic [tag_w-1:0]   rs2_tag,
    output rob_pkg::data_t     rs1_value,
    output rob_pkg::data_t     rs2_value,
    input  logic [tag_w-1:0]   q1,
    input  logic [tag_w-1:0]   q2,
    output logic               q1_ready,
    output logic               q2_ready,
    output rob_pkg::data_t     q1_data,
    output rob_pkg::data_t     q2_data,
    input  logic               alu_wb_valid,
    input  logic [tag_w-1:0]   alu_wb_rob_id,
    input  rob_pkg::data_t     alu_wb_result,
    input  rob_pkg::addr_t     alu_wb_target_pc,
    input  logic               alu_wb_jump,
    input  logic               mem_wb_valid,
    input  logic [tag_w-1:0]   mem_wb_rob_id,
    input  rob_pkg::data_t     mem_wb_result,
    input  logic [tag_w-1:0]   store_ready_rob_id,
    input  logic [tag_w-1:0]   io_rob_id,
    output logic [tag_w-1:0]   head_io_rob_id,
    output logic               commit_valid,
    output rob_pkg::reg_idx_t  commit_rd,
    output logic [tag_w-1:0]   commit_tag,
    output rob_pkg::data_t     commit_value,
    output logic               commit_jump,
    output rob_pkg::addr_t     commit_target,
    input  logic               cfg_we,
    input  rob_pkg::cfg_addr_t cfg_addr,
    input  rob_pkg::data_t     cfg_wdata,
    output rob_pkg::data_t     cfg_rdata
);
    import rob_pkg::*;

    logic  hold;
    data_t full_margin;

    rob_wb_if #(.rob_depth(rob_depth)) alu_wb ();
    rob_commit_if #(.rob_depth(rob_depth)) commit ();

    assign alu_wb.valid     = alu_wb_valid;
    assign alu_wb.rob_id    = alu_wb_rob_id;
    assign alu_wb.result    = alu_wb_result;
    assign alu_wb.target_pc = alu_wb_target_pc;
    assign alu_wb.jump      = alu_wb_jump;

    assign commit_valid  = commit.valid;
    assign commit_rd     = commit.rd;
    assign commit_tag    = commit.tag;
    assign commit_value  = commit.value;
    assign commit_jump   = commit.jump;
    assign commit_target = commit.target_pc;

    // remaining ports connect by name
    reorder_buffer #(.rob_depth(rob_depth)) reorder_buffer_i (
        .alu_wb (alu_wb),
        .commit (commit),
        .*
    );

    rename_regfile #(.rob_depth(rob_depth)) rename_regfile_i (
        .commit (commit),
        .*
    );

    rob_ctrl_regs rob_ctrl_regs_i (
        .commit (commit),
        .*
    );

endmodule

// File: sim/tb_rob_core.sv
`timescale 1ns/1ns

module tb_rob_core;
    import rob_pkg::*;

    localparam int rob_depth = 8;
    localparam int tag_w = $clog2(rob_depth) + 1;
    // all six tests together take a few hundred cycles
    localparam int max_cycles = 2000;

    typedef logic [tag_w-1:0] tag_t;

    logic      clk;
    logic      rst_n;
    logic      dispatch_valid;
    reg_idx_t  dispatch_rd;
    tag_t      dispatch_rob_id;
    logic      full;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    tag_t      rs1_tag;
    tag_t      rs2_tag;
    data_t     rs1_value;
    data_t     rs2_value;
    tag_t      q1;
    tag_t      q2;
    logic      q1_ready;
    logic      q2_ready;
    data_t     q1_data;
    data_t     q2_data;
    logic      alu_wb_valid;
    tag_t      alu_wb_rob_id;
    data_t     alu_wb_result;
    addr_t     alu_wb_target_pc;
    logic      alu_wb_jump;
    logic      mem_wb_valid;
    tag_t      mem_wb_rob_id;
    data_t     mem_wb_result;
    tag_t      store_ready_rob_id;
    tag_t      io_rob_id;
    tag_t      head_io_rob_id;
    logic      commit_valid;
    reg_idx_t  commit_rd;
    tag_t      commit_tag;
    data_t     commit_value;
    logic      commit_jump;
    addr_t     commit_target;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    data_t     cfg_wdata;
    data_t     cfg_rdata;

    // tag the next dispatch should get, and commit beats seen so far
    tag_t        next_tag;
    int          commits;
    int          cycles;

    rob_core_top #(.rob_depth(rob_depth)) rob_core_top_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_reg_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s is x%0d, expected x%0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_tag(input string what, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s is tag %0d, expected tag %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // inputs change 2 ns after the edge, outputs are sampled 1 ns later
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic settle();
        #1;
    endtask

    task automatic dispatch(input reg_idx_t rd, output tag_t tag);
        check_tag("dispatch_rob_id", dispatch_rob_id, next_tag);
        tag = next_tag;
        dispatch_valid = 1'b1;
        dispatch_rd    = rd;
        tick();
        dispatch_valid = 1'b0;
        next_tag = (next_tag == tag_t'(rob_depth)) ? tag_t'(1) : next_tag + 1'b1;
    endtask

    task automatic alu_write(input tag_t tag, input data_t value, input logic jump,
                             input addr_t target);
        alu_wb_valid     = 1'b1;
        alu_wb_rob_id    = tag;
        alu_wb_result    = value;
        alu_wb_jump      = jump;
        alu_wb_target_pc = target;
        tick();
        alu_wb_valid = 1'b0;
        alu_wb_jump  = 1'b0;
    endtask

    task automatic mem_write(input tag_t tag, input data_t value);
        mem_wb_valid  = 1'b1;
        mem_wb_rob_id = tag;
        mem_wb_result = value;
        tick();
        mem_wb_valid = 1'b0;
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input data_t value);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = value;
        tick();
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t addr, output data_t value);
        cfg_addr = addr;
        settle();
        value = cfg_rdata;
    endtask

    // waits at most limit cycles for the beat, then steps past it
    task automatic next_commit(input reg_idx_t rd, input tag_t tag, input data_t value,
                               input logic jump, input addr_t target, input int limit);
        int waited;
        waited = 0;
        while (commit_valid !== 1'b1) begin
            if (waited >= limit) begin
                fail_run($sformatf("commit of tag %0d did not arrive within %0d cycles",
                    tag, limit));
            end
            tick();
            waited++;
        end
        check_reg_idx("commit_rd", commit_rd, rd);
        check_tag("commit_tag", commit_tag, tag);
        check_data("commit_value", commit_value, value);
        check_bit("commit_jump", commit_jump, jump);
        check_data("commit_target", commit_target, target);
        commits++;
        tick();
    endtask

    task automatic no_commit_for(input int n);
        for (int i = 0; i < n; i++) begin
            check_bit("commit_valid while idle", commit_valid, 1'b0);
            tick();
        end
    endtask

    task automatic all_tags_clear(input logic values_too);
        for (int i = 0; i < 16; i++) begin
            rs1_idx = reg_idx_t'(i);
            rs2_idx = reg_idx_t'(i + 16);
            settle();
            check_tag($sformatf("rs1_tag of x%0d", i), rs1_tag, '0);
            check_tag($sformatf("rs2_tag of x%0d", i + 16), rs2_tag, '0);
            if (values_too) begin
                check_data($sformatf("value of x%0d", i), rs1_value, '0);
                check_data($sformatf("value of x%0d", i + 16), rs2_value, '0);
            end
            tick();
        end
    endtask

    task automatic reset_state();
        data_t got;
        check_bit("commit_valid", commit_valid, 1'b0);
        check_bit("commit_jump", commit_jump, 1'b0);
        check_bit("full", full, 1'b0);
        check_tag("dispatch_rob_id", dispatch_rob_id, tag_t'(1));
        check_tag("head_io_rob_id", head_io_rob_id, '0);
        cfg_read(CFG_MARGIN, got);
        check_data("margin after reset", got, 32'd4);
        all_tags_clear(1'b1);
    endtask

    task automatic in_order_retire();
        tag_t  t1;
        tag_t  t2;
        tag_t  t3;
        data_t v1;
        data_t v2;
        data_t v3;
        v1 = $urandom();
        v2 = $urandom();
        v3 = $urandom();
        dispatch(5'd3, t1);
        dispatch(5'd4, t2);
        dispatch(5'd5, t3);
        alu_write(t3, v3, 1'b0, '0);
        mem_write(t1, v1);
        check_bit("commit_valid as head turns ready", commit_valid, 1'b0);
        alu_write(t2, v2, 1'b0, '0);
        // each beat one cycle after its entry is ready at the head
        next_commit(5'd3, t1, v1, 1'b0, '0, 0);
        next_commit(5'd4, t2, v2, 1'b0, '0, 0);
        next_commit(5'd5, t3, v3, 1'b0, '0, 0);
        check_bit("commit_valid after last beat", commit_valid, 1'b0);
        rs1_idx = 5'd3;
        rs2_idx = 5'd4;
        settle();
        check_data("value of x3", rs1_value, v1);
        check_data("value of x4", rs2_value, v2);
        check_tag("tag of x3", rs1_tag, '0);
        rs1_idx = 5'd5;
        settle();
        check_data("value of x5", rs1_value, v3);
    endtask

    task automatic query_store_io();
        tag_t  ta;
        tag_t  ts;
        data_t v;
        v = $urandom();
        dispatch(5'd8, ta);
        // store, no destination register
        dispatch(5'd0, ts);
        q1 = ta;
        settle();
        check_bit("q1_ready before writeback", q1_ready, 1'b0);
        io_rob_id = ta;
        tick();
        io_rob_id = '0;
        check_tag("head_io_rob_id", head_io_rob_id, ta);
        alu_write(ta, v, 1'b0, '0);
        q1 = ta;
        q2 = '0;
        settle();
        check_bit("q1_ready after writeback", q1_ready, 1'b1);
        check_data("q1_data", q1_data, v);
        check_bit("q2_ready for tag 0", q2_ready, 1'b0);
        check_data("q2_data for tag 0", q2_data, '0);
        next_commit(5'd8, ta, v, 1'b0, '0, 1);
        check_tag("head_io_rob_id after io commit", head_io_rob_id, '0);
        store_ready_rob_id = ts;
        tick();
        store_ready_rob_id = '0;
        next_commit(5'd0, ts, '0, 1'b0, '0, 1);
        q1 = '0;
    endtask

    task automatic rename_tags();
        tag_t  t_old;
        tag_t  t_new;
        data_t va;
        data_t vb;
        va = $urandom();
        vb = $urandom();
        dispatch(5'd7, t_old);
        dispatch(5'd7, t_new);
        rs1_idx = 5'd7;
        settle();
        check_tag("tag of x7 after two renames", rs1_tag, t_new);
        mem_write(t_old, va);
        next_commit(5'd7, t_old, va, 1'b0, '0, 1);
        check_tag("tag of x7 after older commit", rs1_tag, t_new);
        check_data("value of x7 after older commit", rs1_value, va);
        alu_write(t_new, vb, 1'b0, '0);
        next_commit(5'd7, t_new, vb, 1'b0, '0, 1);
        check_tag("tag of x7 after newer commit", rs1_tag, '0);
        check_data("value of x7 after newer commit", rs1_value, vb);
    endtask

    task automatic full_margin_hold();
        tag_t  tags [7];
        data_t vals [7];
        data_t got;
        for (int i = 0; i < 4; i++) begin
            dispatch(reg_idx_t'(10 + i), tags[i]);
            check_bit($sformatf("full with %0d live, margin 4", i + 1), full, i == 3);
        end
        cfg_write(CFG_MARGIN, 32'd1);
        check_bit("full after margin 1", full, 1'b0);
        for (int i = 4; i < 7; i++) begin
            dispatch(reg_idx_t'(10 + i), tags[i]);
            check_bit($sformatf("full with %0d live, margin 1", i + 1), full, i == 6);
        end
        for (int i = 1; i < 7; i++) begin
            vals[i] = $urandom();
            if (i % 2 == 1) begin
                alu_write(tags[i], vals[i], 1'b0, '0);
            end else begin
                mem_write(tags[i], vals[i]);
            end
        end
        check_bit("commit_valid with head not ready", commit_valid, 1'b0);
        // head result and hold land at the same edge
        vals[0]       = $urandom();
        alu_wb_valid  = 1'b1;
        alu_wb_rob_id = tags[0];
        alu_wb_result = vals[0];
        cfg_we        = 1'b1;
        cfg_addr      = CFG_CTRL;
        cfg_wdata     = 32'd1;
        tick();
        alu_wb_valid = 1'b0;
        cfg_we       = 1'b0;
        no_commit_for(5);
        q1 = tags[0];
        settle();
        check_bit("q1_ready during hold", q1_ready, 1'b1);
        check_data("q1_data during hold", q1_data, vals[0]);
        q1 = '0;
        cfg_write(CFG_CTRL, 32'd0);
        for (int i = 0; i < 7; i++) begin
            next_commit(reg_idx_t'(10 + i), tags[i], vals[i], 1'b0, '0, (i == 0) ? 2 : 0);
        end
        cfg_read(CFG_COMMITS, got);
        check_data("commit counter", got, data_t'(commits));
        cfg_write(CFG_MARGIN, 32'd4);
    endtask

    task automatic jump_flush();
        tag_t  tj;
        tag_t  ty1;
        tag_t  ty2;
        tag_t  ty3;
        data_t vj;
        data_t vy;
        addr_t target;
        data_t got;
        vj     = $urandom();
        vy     = $urandom();
        target = $urandom() & 32'hffff_fffc;
        dispatch(5'd1, tj);
        dispatch(5'd2, ty1);
        dispatch(5'd9, ty2);
        dispatch(5'd11, ty3);
        check_bit("full before flush", full, 1'b1);
        alu_write(ty1, vy, 1'b0, '0);
        alu_write(tj, vj, 1'b1, target);
        next_commit(5'd1, tj, vj, 1'b1, target, 1);
        // younger ready entry would retire right here without the flush
        no_commit_for(5);
        next_tag = tag_t'(1);
        check_tag("dispatch_rob_id after flush", dispatch_rob_id, tag_t'(1));
        check_bit("full after flush", full, 1'b0);
        rs1_idx = 5'd1;
        settle();
        check_data("value of x1 after jump", rs1_value, vj);
        all_tags_clear(1'b0);
        cfg_read(CFG_FLUSHES, got);
        check_data("flush counter", got, 32'd1);
    endtask

    initial begin
        void'($urandom(32'hb4df));
        clk                = 1'b0;
        rst_n              = 1'b0;
        dispatch_valid     = 1'b0;
        dispatch_rd        = '0;
        rs1_idx            = '0;
        rs2_idx            = '0;
        q1                 = '0;
        q2                 = '0;
        alu_wb_valid       = 1'b0;
        alu_wb_rob_id      = '0;
        alu_wb_result      = '0;
        alu_wb_target_pc   = '0;
        alu_wb_jump        = 1'b0;
        mem_wb_valid       = 1'b0;
        mem_wb_rob_id      = '0;
        mem_wb_result      = '0;
        store_ready_rob_id = '0;
        io_rob_id          = '0;
        cfg_we             = 1'b0;
        cfg_addr           = '0;
        cfg_wdata          = '0;
        next_tag           = tag_t'(1);
        commits            = 0;
        cycles             = 0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reset_state();
        in_order_retire();
        query_store_io();
        rename_tags();
        full_margin_hold();
        jump_flush();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: sources.f
rtl/rob_pkg.sv
rtl/rob_wb_if.sv
rtl/reorder_buffer.sv
rtl/rename_regfile.sv
rtl/rob_ctrl_regs.sv
rtl/rob_core_top.sv
sim/tb_rob_core.sv

// File: Bender.yml
package:
  name: rob_core

sources:
  - rtl/rob_pkg.sv
  - rtl/rob_wb_if.sv
  - rtl/reorder_buffer.sv
  - rtl/rename_regfile.sv
  - rtl/rob_ctrl_regs.sv
  - rtl/rob_core_top.sv
  - target: simulation
    files:
      - sim/tb_rob_core.sv
